// ==== compile.f ====
src/l2_pkg.sv
src/l2_cache_arb.sv
src/l2_cache_tag_way.sv
src/l2_cache_hit_select.sv
src/l2_cache_miss_queue.sv
src/l2_cache.sv
sim/l2_cache_tb.sv

// ==== sim/l2_cache_tb.sv ====
`timescale 1ns/10ps
// L2 cache testbench
// Drives a table of loads and stores through the shared request port and
// answers line reads from a memory model with random latency. Every
// response and every write-through is checked against a shadow word memory
module l2_cache_tb
	import l2_pkg::*;
	();

	localparam int NUM_ROWS = 24;
	localparam int RESET_CYCLES = 8;
	localparam int KEY_WIDTH = CORE_WIDTH + TAG_ID_WIDTH;

	// Gap counts the idle cycles before a row is issued
	typedef struct packed {
		l2_op_t op;
		logic [ADDR_WIDTH-1:0] address;
		logic [WORD_WIDTH-1:0] data;
		logic [BYTES_PER_WORD-1:0] mask;
		logic [CORE_WIDTH-1:0] core;
		logic expect_read;
		logic [7:0] gap;
	} stim_row_t;

	// What an outstanding request has to answer with
	typedef struct packed {
		logic pending;
		logic is_store;
		logic [ADDR_WIDTH-1:0] address;
		logic [WORD_WIDTH-1:0] data;
		logic [BYTES_PER_WORD-1:0] mask;
	} expect_t;

	logic clk;
	logic reset;
	logic req_valid;
	l2_req_t req;
	logic req_ready;
	logic resp_valid;
	logic [CORE_WIDTH-1:0] resp_core;
	logic [TAG_ID_WIDTH-1:0] resp_tag_id;
	logic [WORD_WIDTH-1:0] resp_data;
	logic mem_write;
	logic [ADDR_WIDTH-1:0] mem_write_address;
	logic [WORD_WIDTH-1:0] mem_write_data;
	logic [BYTES_PER_WORD-1:0] mem_write_mask;
	logic mem_read;
	logic [LINE_ADDR_WIDTH-1:0] mem_read_line_address;
	logic mem_read_valid;
	line_t mem_read_data;

	stim_row_t rows [NUM_ROWS];
	expect_t expected [1 << KEY_WIDTH];
	logic [WORD_WIDTH-1:0] memory [1 << ADDR_WIDTH];
	logic [WORD_WIDTH-1:0] shadow [1 << ADDR_WIDTH];
	int read_expect [1 << LINE_ADDR_WIDTH];
	int row_count;
	int seed;
	int read_wait;
	logic [LINE_ADDR_WIDTH-1:0] read_line;
	int error_count;
	int resp_count;
	int outstanding;
	int reads_outstanding;
	int watchdog_cycles;
	int max_gap;
	logic issued_any;
	logic stall_seen;

	l2_cache u_l2_cache (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_core(resp_core),
		.resp_tag_id(resp_tag_id),
		.resp_data(resp_data),
		.mem_write(mem_write),
		.mem_write_address(mem_write_address),
		.mem_write_data(mem_write_data),
		.mem_write_mask(mem_write_mask),
		.mem_read(mem_read),
		.mem_read_line_address(mem_read_line_address),
		.mem_read_valid(mem_read_valid),
		.mem_read_data(mem_read_data)
	);

	initial
		clk = 1'b0;
	always #20 clk = ~clk;

	// Memory contents before any store differ for every word address
	function automatic logic [WORD_WIDTH-1:0] fill_pattern(input logic [ADDR_WIDTH-1:0] address);
		return {address ^ 16'ha5c3, ~address};
	endfunction

	// Each byte enable widens to eight bits that pick the store's byte
	function automatic logic [WORD_WIDTH-1:0] store_merge(
		input logic [WORD_WIDTH-1:0] old_word,
		input logic [WORD_WIDTH-1:0] new_word,
		input logic [BYTES_PER_WORD-1:0] mask);
		logic [WORD_WIDTH-1:0] bit_mask;
		bit_mask = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
		return (new_word & bit_mask) | (old_word & ~bit_mask);
	endfunction

	task automatic report_failure(input string text);
		$display("%s", text);
		error_count++;
	endtask

	task automatic value_error(input string name, input logic [WORD_WIDTH-1:0] want,
		input logic [WORD_WIDTH-1:0] got);
		$display("error %s (core %0d tag %h): expected %h, actual %h",
			name, resp_core, resp_tag_id, want, got);
		error_count++;
	endtask

	task automatic add_row(input l2_op_t op, input logic [ADDR_WIDTH-1:0] address,
		input logic [WORD_WIDTH-1:0] data, input logic [BYTES_PER_WORD-1:0] mask,
		input logic [CORE_WIDTH-1:0] core, input logic expect_read, input int gap);
		rows[row_count].op = op;
		rows[row_count].address = address;
		rows[row_count].data = data;
		rows[row_count].mask = mask;
		rows[row_count].core = core;
		rows[row_count].expect_read = expect_read;
		rows[row_count].gap = gap[7:0];
		row_count++;
	endtask

	// Records what the row must answer, then holds the request until accepted
	task automatic issue_row(input int index);
		stim_row_t row;
		logic [KEY_WIDTH-1:0] key;
		logic [WORD_WIDTH-1:0] word;
		row = rows[index];
		repeat (row.gap)
		begin
			@(posedge clk);
			#2;
		end
		// The tag id alone repeats after 16 rows, so the core is part of the key
		key = {row.core, index[TAG_ID_WIDTH-1:0]};
		word = shadow[row.address];
		if (row.op == op_store)
		begin
			word = store_merge(word, row.data, row.mask);
			shadow[row.address] = word;
		end
		expected[key].pending = 1'b1;
		expected[key].is_store = row.op == op_store;
		expected[key].address = row.address;
		expected[key].data = word;
		expected[key].mask = row.mask;
		outstanding++;
		if (row.expect_read)
		begin
			read_expect[row.address[ADDR_WIDTH-1:OFFSET_WIDTH]]++;
			reads_outstanding++;
		end
		req.core = row.core;
		req.tag_id = index[TAG_ID_WIDTH-1:0];
		req.op = row.op;
		req.address = row.address;
		req.data = row.data;
		req.mask = row.mask;
		req_valid = 1'b1;
		issued_any = 1'b1;
		// Ready is stable in the low phase, so the next rising edge takes it
		@(negedge clk);
		while (req_ready !== 1'b1)
			@(negedge clk);
		@(posedge clk);
		#2;
		req_valid = 1'b0;
	endtask

	task automatic check_response();
		logic [KEY_WIDTH-1:0] key;
		expect_t want;
		key = {resp_core, resp_tag_id};
		want = expected[key];
		resp_count++;
		if (!want.pending)
			report_failure($sformatf("response for core %0d tag %h matches no request",
				resp_core, resp_tag_id));
		else
		begin
			if (resp_data !== want.data)
				value_error("resp_data", want.data, resp_data);
			if (want.is_store && mem_write !== 1'b1)
				report_failure("store response came without its memory write");
			else if (want.is_store)
			begin
				if (mem_write_address !== want.address)
					value_error("mem_write_address", want.address, mem_write_address);
				if (mem_write_data !== want.data)
					value_error("mem_write_data", want.data, mem_write_data);
				if (mem_write_mask !== want.mask)
					value_error("mem_write_mask", want.mask, mem_write_mask);
			end
			else if (mem_write !== 1'b0)
				report_failure("load response came with a memory write");
			expected[key].pending = 1'b0;
			outstanding--;
		end
	endtask

	// The memory model applies writes at once and answers a read 2 to 9 cycles later
	always @(negedge clk)
	begin
		if (!reset && mem_write === 1'b1)
			memory[mem_write_address] = store_merge(memory[mem_write_address],
				mem_write_data, mem_write_mask);
		if (!reset && mem_read === 1'b1)
		begin
			if (read_wait != 0)
				report_failure("a second memory read was issued while one was outstanding");
			read_line = mem_read_line_address;
			read_wait = 2 + {$random(seed)} % 8;
		end
	end

	// The line is taken as memory holds it at the time of the answer
	always @(posedge clk)
	begin
		#2;
		mem_read_valid = 1'b0;
		if (read_wait != 0)
		begin
			read_wait--;
			if (read_wait == 0)
			begin
				for (int w = 0; w < LINE_WORDS; w++)
					mem_read_data[w] = memory[{read_line, w[OFFSET_WIDTH-1:0]}];
				mem_read_valid = 1'b1;
			end
		end
	end

	// Outputs are sampled in the low phase, away from the rising edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (!issued_any && req_ready !== 1'b1)
				report_failure("req_ready is not high after reset");
			if (!issued_any && (resp_valid !== 1'b0 || mem_read !== 1'b0 || mem_write !== 1'b0))
				report_failure("an output pulsed after reset before any request");
			if (req_valid && req_ready !== 1'b1)
				stall_seen = 1'b1;
			if (resp_valid === 1'b1)
				check_response();
			else if (mem_write === 1'b1)
				report_failure("memory write without a store response");
			// Only rows flagged for a read may fetch their line
			if (mem_read === 1'b1 && read_expect[mem_read_line_address] == 0)
				report_failure($sformatf("unexpected memory read of line %h",
					mem_read_line_address));
			else if (mem_read === 1'b1)
			begin
				read_expect[mem_read_line_address]--;
				reads_outstanding--;
			end
		end
	end

	initial
	begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout with %0d responses still outstanding", outstanding);
		$display("%0d errors in %0d responses", error_count, resp_count);
		$display("Errors found");
		$finish;
	end

	initial
	begin
		seed = 27;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		mem_read_valid = 1'b0;
		mem_read_data = '0;
		issued_any = 1'b0;
		stall_seen = 1'b0;
		for (int a = 0; a < (1 << ADDR_WIDTH); a++)
		begin
			memory[a] = fill_pattern(a[ADDR_WIDTH-1:0]);
			shadow[a] = memory[a];
		end
		for (int k = 0; k < (1 << KEY_WIDTH); k++)
			expected[k] = '0;

		// A miss, a hit on the filled line, then a store hit and its reload
		add_row(op_load, 16'h0040, 32'h00000000, 4'h0, 2'd0, 1'b1, 0);
		add_row(op_load, 16'h0041, 32'h00000000, 4'h0, 2'd0, 1'b0, 30);
		add_row(op_store, 16'h0042, 32'ha1b2c3d4, 4'h3, 2'd1, 1'b0, 2);
		add_row(op_load, 16'h0042, 32'h00000000, 4'h0, 2'd1, 1'b0, 6);
		// Two loads back to back on one uncached line share one read
		add_row(op_load, 16'h0104, 32'h00000000, 4'h0, 2'd2, 1'b1, 8);
		add_row(op_load, 16'h0106, 32'h00000000, 4'h0, 2'd3, 1'b0, 0);
		// Store miss merges into the fetched line
		add_row(op_store, 16'h0209, 32'h55667788, 4'hc, 2'd0, 1'b1, 30);
		add_row(op_load, 16'h0209, 32'h00000000, 4'h0, 2'd0, 1'b0, 30);
		// Eight misses to eight sets fill the queue and stall the port
		add_row(op_load, 16'h030c, 32'h00000000, 4'h0, 2'd1, 1'b1, 10);
		add_row(op_load, 16'h0310, 32'h00000000, 4'h0, 2'd1, 1'b1, 0);
		add_row(op_load, 16'h0314, 32'h00000000, 4'h0, 2'd2, 1'b1, 0);
		add_row(op_store, 16'h0318, 32'h0badf00d, 4'hf, 2'd2, 1'b1, 0);
		add_row(op_load, 16'h031c, 32'h00000000, 4'h0, 2'd3, 1'b1, 0);
		add_row(op_load, 16'h0320, 32'h00000000, 4'h0, 2'd3, 1'b1, 0);
		add_row(op_store, 16'h0324, 32'h12345678, 4'h5, 2'd0, 1'b1, 0);
		add_row(op_load, 16'h0328, 32'h00000000, 4'h0, 2'd0, 1'b1, 0);
		// Hits on the lines of the run once it has drained
		add_row(op_load, 16'h0318, 32'h00000000, 4'h0, 2'd1, 1'b0, 64);
		add_row(op_load, 16'h0328, 32'h00000000, 4'h0, 2'd2, 1'b0, 0);
		add_row(op_load, 16'h0324, 32'h00000000, 4'h0, 2'd3, 1'b0, 0);
		add_row(op_store, 16'h0043, 32'hee000000, 4'h8, 2'd0, 1'b0, 4);
		add_row(op_load, 16'h0043, 32'h00000000, 4'h0, 2'd0, 1'b0, 6);
		// A second line in set 0 and its duplicate, then the first line again
		add_row(op_load, 16'h0400, 32'h00000000, 4'h0, 2'd1, 1'b1, 10);
		add_row(op_load, 16'h0403, 32'h00000000, 4'h0, 2'd2, 1'b0, 0);
		add_row(op_load, 16'h0042, 32'h00000000, 4'h0, 2'd3, 1'b0, 30);

		max_gap = 0;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			if (rows[i].gap > max_gap)
				max_gap = rows[i].gap;
		end
		watchdog_cycles = RESET_CYCLES + NUM_ROWS * (max_gap + 30);

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++)
			issue_row(i);

		// Responses may still be on their way back from memory
		while (outstanding != 0)
			@(posedge clk);
		repeat (12) @(posedge clk);
		if (reads_outstanding != 0)
			report_failure($sformatf("%0d expected memory reads never happened",
				reads_outstanding));
		if (!stall_seen)
			report_failure("req_ready never dropped during the run of misses");
		$display("%0d errors in %0d responses", error_count, resp_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end
endmodule

// ==== src/l2_cache.sv ====
`timescale 1ns/10ps
// L2 cache top level
// Shared request port in front of a four-stage pipeline: arbitration, one
// tag lookup per way, hit resolution with the data array, and the miss
// queue that fetches lines from memory and feeds requests back in
module l2_cache
	import l2_pkg::*;
	#(
	parameter int NUM_WAYS = 4,
	parameter int NUM_SETS = 16,
	parameter int QUEUE_DEPTH = 4
	)
	(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input l2_req_t req,
	output logic req_ready,
	output logic resp_valid,
	output logic [CORE_WIDTH-1:0] resp_core,
	output logic [TAG_ID_WIDTH-1:0] resp_tag_id,
	output logic [WORD_WIDTH-1:0] resp_data,
	output logic mem_write,
	output logic [ADDR_WIDTH-1:0] mem_write_address,
	output logic [WORD_WIDTH-1:0] mem_write_data,
	output logic [BYTES_PER_WORD-1:0] mem_write_mask,
	output logic mem_read,
	output logic [LINE_ADDR_WIDTH-1:0] mem_read_line_address,
	input logic mem_read_valid,
	input line_t mem_read_data
	);

	l2_arb_t arb;
	logic [NUM_WAYS-1:0] way_hit;
	l2_arb_t way_lookup [NUM_WAYS];
	logic miss_valid;
	l2_miss_t miss;
	logic restart_valid;
	l2_miss_t restart;
	line_t restart_line;
	logic restart_duplicate;
	logic queue_wait;

	l2_cache_arb u_arb (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.restart_valid(restart_valid),
		.restart(restart),
		.restart_line(restart_line),
		.restart_duplicate(restart_duplicate),
		.queue_wait(queue_wait),
		.req_ready(req_ready),
		.arb(arb)
	);

	// Every way registers the same copy of the lookup, and way 0's is used
	for (genvar i = 0; i < NUM_WAYS; i++)
	begin : gen_way
		l2_cache_tag_way #(
			.WAY_INDEX(i),
			.NUM_SETS(NUM_SETS)
		) u_tag_way (
			.clk(clk),
			.reset(reset),
			.arb(arb),
			.way_hit(way_hit[i]),
			.lookup(way_lookup[i])
		);
	end

	l2_cache_hit_select #(
		.NUM_WAYS(NUM_WAYS),
		.NUM_SETS(NUM_SETS)
	) u_hit_select (
		.clk(clk),
		.reset(reset),
		.way_hit(way_hit),
		.lookup(way_lookup[0]),
		.resp_valid(resp_valid),
		.resp_core(resp_core),
		.resp_tag_id(resp_tag_id),
		.resp_data(resp_data),
		.mem_write(mem_write),
		.mem_write_address(mem_write_address),
		.mem_write_data(mem_write_data),
		.mem_write_mask(mem_write_mask),
		.miss_valid(miss_valid),
		.miss(miss)
	);

	l2_cache_miss_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_miss_queue (
		.clk(clk),
		.reset(reset),
		.miss_valid(miss_valid),
		.miss(miss),
		.mem_read_valid(mem_read_valid),
		.mem_read_data(mem_read_data),
		.queue_wait(queue_wait),
		.mem_read(mem_read),
		.mem_read_line_address(mem_read_line_address),
		.restart_valid(restart_valid),
		.restart(restart),
		.restart_line(restart_line),
		.restart_duplicate(restart_duplicate)
	);
endmodule

// ==== src/l2_cache_arb.sv ====
`timescale 1ns/10ps
// L2 cache arbitration stage
// Picks what enters the pipeline each cycle: a restarted request from the
// miss queue or a new request from the shared core port. Restarts always
// win, and core requests are held off while the miss queue is nearly full
module l2_cache_arb
	import l2_pkg::*;
	(
	input logic clk,
	input logic reset,
	input logic req_valid,
	input l2_req_t req,
	input logic restart_valid,
	input l2_miss_t restart,
	input line_t restart_line,
	input logic restart_duplicate,
	input logic queue_wait,
	output logic req_ready,
	output l2_arb_t arb
	);

	logic core_accept;

	// The core port stalls in a cycle that carries a restart, and also
	// while the queue only has room for the requests already in flight
	assign req_ready = !restart_valid && !queue_wait;

	// Handshake with the core port
	assign core_accept = req_valid && req_ready;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			arb <= '0;
		else if (restart_valid)
		begin
			// A fetched line comes back with the request that missed on it
			// and has to be written into the victim way
			arb.valid <= 1'b1;
			arb.req <= restart.req;
			// A duplicate already finds its line in the cache, so it goes
			// down the pipe as an ordinary lookup
			arb.restarted <= !restart_duplicate;
			arb.way <= restart.way;
			arb.fill_line <= restart_line;
		end
		else
		begin
			// An empty slot when the port is idle or stalled
			arb.valid <= core_accept;
			arb.req <= req;
			arb.restarted <= 1'b0;
			arb.way <= '0;
			arb.fill_line <= '0;
		end
	end

	// A restart and a core request never enter the pipeline in the same cycle
	assert property (@(posedge clk) disable iff (reset)
		!(restart_valid && core_accept));
endmodule

// ==== src/l2_cache_hit_select.sv ====
`timescale 1ns/10ps
// L2 cache hit resolution stage
// Merges the hits of all ways, reads and writes the data array and builds
// the response. Stores write through to memory. A miss picks a victim way
// from a per-set round-robin counter and goes to the miss queue
module l2_cache_hit_select
	import l2_pkg::*;
	#(
	parameter int NUM_WAYS = 4,
	parameter int NUM_SETS = 16
	)
	(
	input logic clk,
	input logic reset,
	input logic [NUM_WAYS-1:0] way_hit,
	input l2_arb_t lookup,
	output logic resp_valid,
	output logic [CORE_WIDTH-1:0] resp_core,
	output logic [TAG_ID_WIDTH-1:0] resp_tag_id,
	output logic [WORD_WIDTH-1:0] resp_data,
	output logic mem_write,
	output logic [ADDR_WIDTH-1:0] mem_write_address,
	output logic [WORD_WIDTH-1:0] mem_write_data,
	output logic [BYTES_PER_WORD-1:0] mem_write_mask,
	output logic miss_valid,
	output l2_miss_t miss
	);

	localparam int SET_BITS = $clog2(NUM_SETS);
	localparam int WAY_BITS = $clog2(NUM_WAYS);

	line_t data_mem [NUM_WAYS][NUM_SETS];
	logic [WAY_BITS-1:0] victim_way [NUM_SETS];
	logic [LINE_ADDR_WIDTH-1:0] line_addr;
	logic [SET_BITS-1:0] set_index;
	logic [OFFSET_WIDTH-1:0] word_index;
	logic [WAY_BITS-1:0] hit_way;
	logic hit_any;
	logic is_store;
	logic respond;
	logic update_data;
	line_t base_line;
	line_t update_line;
	logic [WORD_WIDTH-1:0] old_word;
	logic [WORD_WIDTH-1:0] merged_word;

	assign line_addr = line_address(lookup.req.address);
	assign set_index = line_addr[SET_BITS-1:0];
	assign word_index = lookup.req.address[OFFSET_WIDTH-1:0];
	assign is_store = lookup.req.op == op_store;

	// The hits are one-hot, so a plain encoder finds the way
	always_comb
	begin
		hit_way = '0;
		for (int i = 0; i < NUM_WAYS; i++)
		begin
			if (way_hit[i])
				hit_way = i[WAY_BITS-1:0];
		end
	end

	assign hit_any = |way_hit;
	assign respond = lookup.valid && hit_any;

	// A fill reports a hit in its victim way but takes its data from memory
	// instead of the stale array contents
	assign base_line = lookup.restarted ? lookup.fill_line : data_mem[hit_way][set_index];
	assign old_word = base_line[word_index];
	assign merged_word = merge_word(old_word, lookup.req.data, lookup.req.mask);

	always_comb
	begin
		update_line = base_line;
		if (is_store)
			update_line[word_index] = merged_word;
	end

	// The array changes on every fill and on every store hit
	assign update_data = lookup.valid && (lookup.restarted || (hit_any && is_store));

	always_ff @(posedge clk)
	begin
		if (update_data)
			data_mem[hit_way][set_index] <= update_line;
	end

	// Missed requests go straight into the queue along with their victim
	assign miss_valid = lookup.valid && !hit_any;
	assign miss = '{req: lookup.req, way: WAY_WIDTH'(victim_way[set_index])};

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			resp_valid <= 1'b0;
			mem_write <= 1'b0;
			for (int i = 0; i < NUM_SETS; i++)
				victim_way[i] <= '0;
		end
		else
		begin
			resp_valid <= respond;
			// Stores write through in the same cycle as their response
			mem_write <= respond && is_store;
			if (miss_valid)
				victim_way[set_index] <= victim_way[set_index] + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		resp_core <= lookup.req.core;
		resp_tag_id <= lookup.req.tag_id;
		// A store answers with the word as it now stands in the cache
		resp_data <= is_store ? merged_word : old_word;
		mem_write_address <= lookup.req.address;
		mem_write_data <= merged_word;
		mem_write_mask <= lookup.req.mask;
	end

	// The ways drop a duplicate copy of a line when it is fetched again, so
	// no lookup ever hits in two ways at once
	assert property (@(posedge clk) disable iff (reset) $onehot0(way_hit));
endmodule

// ==== src/l2_cache_miss_queue.sv ====
`timescale 1ns/10ps
// L2 cache miss queue
// Keeps missed requests in order and fetches their lines from memory, one
// read at a time. A head entry on the line fetched last needs no read and
// restarts as a duplicate. Each restart goes back through arbitration
module l2_cache_miss_queue
	import l2_pkg::*;
	#(
	parameter int QUEUE_DEPTH = 4
	)
	(
	input logic clk,
	input logic reset,
	input logic miss_valid,
	input l2_miss_t miss,
	input logic mem_read_valid,
	input line_t mem_read_data,
	output logic queue_wait,
	output logic mem_read,
	output logic [LINE_ADDR_WIDTH-1:0] mem_read_line_address,
	output logic restart_valid,
	output l2_miss_t restart,
	output line_t restart_line,
	output logic restart_duplicate
	);

	localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

	l2_miss_t entries [QUEUE_DEPTH];
	logic [PTR_BITS-1:0] read_ptr;
	logic [PTR_BITS-1:0] write_ptr;
	logic [PTR_BITS:0] count;
	logic read_pending;
	logic last_valid;
	logic [LINE_ADDR_WIDTH-1:0] last_line;
	l2_miss_t head;
	logic [LINE_ADDR_WIDTH-1:0] head_line;
	logic head_ready;
	logic head_duplicate;
	logic start_read;
	logic pop;

	assign head = entries[read_ptr];
	assign head_line = line_address(head.req.address);

	// The head is only looked at while no read is out, since the read
	// belongs to it and it must not move until the data returns
	assign head_ready = count != '0 && !read_pending;
	assign head_duplicate = last_valid && head_line == last_line;
	assign start_read = head_ready && !head_duplicate;

	// An entry leaves either as a duplicate or when its line arrives
	assign pop = (head_ready && head_duplicate) || mem_read_valid;

	// Two more misses may already be in the arbitration and tag stages
	assign queue_wait = int'(count) >= QUEUE_DEPTH - 2;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
			read_pending <= 1'b0;
			last_valid <= 1'b0;
			mem_read <= 1'b0;
			restart_valid <= 1'b0;
		end
		else
		begin
			mem_read <= start_read;
			restart_valid <= pop;
			if (start_read)
				read_pending <= 1'b1;
			else if (mem_read_valid)
				read_pending <= 1'b0;
			if (mem_read_valid)
				last_valid <= 1'b1;
			if (miss_valid)
				write_ptr <= write_ptr + 1'b1;
			if (pop)
				read_ptr <= read_ptr + 1'b1;
			case ({miss_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss_valid)
			entries[write_ptr] <= miss;
		if (pop)
		begin
			restart <= head;
			restart_duplicate <= !mem_read_valid;
		end
		if (start_read)
			mem_read_line_address <= head_line;
		if (mem_read_valid)
		begin
			restart_line <= mem_read_data;
			// Remember the line so a later miss on it is not read again
			last_line <= head_line;
		end
	end

	// Arbitration stops core requests early enough that the misses still in
	// the pipeline always find room
	assert property (@(posedge clk) disable iff (reset)
		miss_valid |-> int'(count) < QUEUE_DEPTH);

	// Memory answers only reads that this queue issued
	assert property (@(posedge clk) disable iff (reset)
		mem_read_valid |-> read_pending);
endmodule

// ==== src/l2_cache_tag_way.sv ====
`timescale 1ns/10ps
// L2 cache tag way
// Tag and valid storage for one way of the cache. Compares the stored tag
// of the addressed set with the request and loads a new tag when a fill
// names this way. Hit and lookup leave registered
module l2_cache_tag_way
	import l2_pkg::*;
	#(
	parameter int WAY_INDEX = 0,
	parameter int NUM_SETS = 16
	)
	(
	input logic clk,
	input logic reset,
	input l2_arb_t arb,
	output logic way_hit,
	output l2_arb_t lookup
	);

	localparam int SET_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS = LINE_ADDR_WIDTH - SET_BITS;

	logic [TAG_BITS-1:0] tag_mem [NUM_SETS];
	logic [NUM_SETS-1:0] tag_valid;
	logic [LINE_ADDR_WIDTH-1:0] line_addr;
	logic [SET_BITS-1:0] set_index;
	logic [TAG_BITS-1:0] req_tag;
	logic tag_match;
	logic fill_this_way;

	// The set is the line address modulo the number of sets
	assign line_addr = line_address(arb.req.address);
	assign set_index = line_addr[SET_BITS-1:0];
	assign req_tag = line_addr[LINE_ADDR_WIDTH-1:SET_BITS];

	assign tag_match = tag_valid[set_index] && tag_mem[set_index] == req_tag;

	// The victim way was chosen when the request missed
	assign fill_this_way = arb.valid && arb.restarted && arb.way == WAY_WIDTH'(WAY_INDEX);

	always_ff @(posedge clk)
	begin
		if (fill_this_way)
			tag_mem[set_index] <= req_tag;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			tag_valid <= '0;
			way_hit <= 1'b0;
			lookup <= '0;
		end
		else
		begin
			if (fill_this_way)
				tag_valid[set_index] <= 1'b1;
			else if (arb.valid && arb.restarted && tag_match)
			begin
				// The same line was fetched twice and now lands in another
				// way, so the older copy is dropped to keep hits one-hot
				tag_valid[set_index] <= 1'b0;
			end

			// A fill always hits in its own way and nowhere else
			way_hit <= arb.valid && (fill_this_way || (!arb.restarted && tag_match));
			lookup <= arb;
		end
	end
endmodule

// ==== src/l2_pkg.sv ====
// L2 cache shared definitions
// Geometry of the cache data path, the operation code and the packed
// structs that carry a request from one pipeline stage to the next
package l2_pkg;
	// One data word and the word address space of the memory behind the cache
	localparam int WORD_WIDTH = 32;
	localparam int ADDR_WIDTH = 16;
	localparam int BYTES_PER_WORD = WORD_WIDTH / 8;

	// A line holds four words, so the low address bits select the word
	localparam int LINE_WORDS = 4;
	localparam int OFFSET_WIDTH = $clog2(LINE_WORDS);
	localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

	// Identity of the requester that is echoed back in the response
	localparam int CORE_WIDTH = 2;
	localparam int TAG_ID_WIDTH = 4;

	// Way numbers are wide enough for the largest build of eight ways
	localparam int WAY_WIDTH = 3;

	// Word 0 of a line sits in the low bits
	typedef logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_t;

	typedef enum logic {
		op_load = 1'b0,
		op_store = 1'b1
	} l2_op_t;

	// A request as it arrives on the shared core port
	typedef struct packed {
		logic [CORE_WIDTH-1:0] core;
		logic [TAG_ID_WIDTH-1:0] tag_id;
		l2_op_t op;
		logic [ADDR_WIDTH-1:0] address;
		logic [WORD_WIDTH-1:0] data;
		logic [BYTES_PER_WORD-1:0] mask;
	} l2_req_t;

	// A pipeline slot after arbitration
	// The fill fields only mean something when restarted is set
	typedef struct packed {
		logic valid;
		l2_req_t req;
		logic restarted;
		logic [WAY_WIDTH-1:0] way;
		line_t fill_line;
	} l2_arb_t;

	// A missed request together with the way its line will be loaded into
	typedef struct packed {
		l2_req_t req;
		logic [WAY_WIDTH-1:0] way;
	} l2_miss_t;

	// Strips the word offset from a word address
	function automatic logic [LINE_ADDR_WIDTH-1:0] line_address(
		input logic [ADDR_WIDTH-1:0] address);
		return address[ADDR_WIDTH-1:OFFSET_WIDTH];
	endfunction

	// Replaces the enabled bytes of a stored word with the bytes of a store
	function automatic logic [WORD_WIDTH-1:0] merge_word(
		input logic [WORD_WIDTH-1:0] old_word,
		input logic [WORD_WIDTH-1:0] new_word,
		input logic [BYTES_PER_WORD-1:0] mask);
		logic [WORD_WIDTH-1:0] result;
		result = old_word;
		for (int i = 0; i < BYTES_PER_WORD; i++)
		begin
			if (mask[i])
				result[i*8 +: 8] = new_word[i*8 +: 8];
		end
		return result;
	endfunction
endpackage
